// ==== hw/vit_defines.svh ====
`ifndef VIT_DEFINES_SVH
`define VIT_DEFINES_SVH

// ------------------------------
// rate 1/2 code, g = 7, 5 (octal)
// ------------------------------

`define VIT_K          3   // constraint length
`define VIT_STATE_NUM  4   // 2**(K-1) trellis states

// ------------------------------
// traceback sizes
// ------------------------------

`define VIT_TRB_LENGTH 16  // buffer length L, symbols
`define VIT_BANK_NUM   4   // banks of L decision words each
`define VIT_METRIC_W   6   // path metric width

`endif

// ==== hw/vit_pkg.sv ====
`default_nettype none

`include "vit_defines.svh"

package vit_pkg;

  // ------------------------------
  // trellis and metric types
  // ------------------------------

  // state bit 0 holds the newest input bit, bit 1 the one before
  typedef logic [$clog2(`VIT_STATE_NUM)-1:0] state_t;

  typedef logic [`VIT_METRIC_W-1:0] metric_t;

  typedef metric_t [`VIT_STATE_NUM-1:0] statem_t;   // one metric per state

  typedef logic [`VIT_STATE_NUM-1:0] decision_t;    // survivor bit per state

  // ------------------------------
  // traceback ram addressing
  // ------------------------------

  typedef logic [$clog2(`VIT_BANK_NUM)-1:0]   trb_bidx_t;  // bank index
  typedef logic [$clog2(`VIT_TRB_LENGTH)-1:0] trb_idx_t;   // word in bank

  typedef struct packed {
    trb_bidx_t bidx;
    trb_idx_t  addr;
  } trb_addr_t;

  // predecessor of state s, b is the bit shifted out of the register
  function automatic state_t pre_state(state_t s, logic b);
    return {b, s[`VIT_K-2:1]};
  endfunction

endpackage

`default_nettype wire

// ==== hw/vit_trb_if.sv ====
`default_nettype none

// decision words from the controller into the traceback ram
interface vit_trb_wr_if;
  import vit_pkg::*;

  logic      write;     // one cycle per word
  trb_addr_t waddr;
  logic      sop;
  logic      eop;
  decision_t decision;

  modport ctrl (output write, waddr, sop, eop, decision);
  modport ram  (input  write, waddr, sop, eop, decision);
endinterface

// traceback requests, regular and flush
interface vit_trb_cmd_if;
  import vit_pkg::*;

  logic      start;     // regular traceback, level
  trb_addr_t raddr;
  trb_idx_t  size_m1;
  state_t    state;
  logic      flush;     // end of frame, level
  trb_addr_t fraddr;
  trb_idx_t  fsize_m1;
  state_t    fstate;
  logic      rdy;       // engine idle

  modport ctrl   (output start, raddr, size_m1, state, flush, fraddr, fsize_m1, fstate,
                  input  rdy);
  modport engine (input  start, raddr, size_m1, state, flush, fraddr, fsize_m1, fstate,
                  output rdy);
endinterface

`default_nettype wire

// ==== hw/vit_acs.sv ====
`default_nettype none

`include "vit_defines.svh"

// sym[0] carries the g = 7 code bit, sym[1] the g = 5 bit
module vit_acs (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               sop,
  input  logic               val,
  input  logic               eop,
  input  logic [1:0]         sym,
  output logic               oval,
  output logic               osop,
  output logic               oeop,
  output vit_pkg::statem_t   ostatem,
  output vit_pkg::decision_t odecision
);
  import vit_pkg::*;

  // start value for states the encoder cannot be in at sop
  localparam metric_t INIT_BIG = metric_t'(1 << (`VIT_METRIC_W - 2));

  statem_t   old_m;     // metrics entering this symbol
  statem_t   new_m;
  decision_t new_dec;

  // hamming distance between rx pair and branch p -> {p[0], u}
  function automatic metric_t branch_metric(state_t p, logic u, logic [1:0] rx);
    logic [1:0] code;
    code[0] = u ^ p[0] ^ p[1];  // g = 7
    code[1] = u ^ p[1];         // g = 5
    return metric_t'(rx[0] ^ code[0]) + metric_t'(rx[1] ^ code[1]);
  endfunction

  // ------------------------------
  // metric restart / normalization
  // ------------------------------

  always_comb begin
    logic all_top;
    all_top = 1'b1;
    for (int s = 0; s < `VIT_STATE_NUM; s++) begin
      all_top &= ostatem[s][`VIT_METRIC_W-1];
    end
    for (int s = 0; s < `VIT_STATE_NUM; s++) begin
      if (sop) begin
        old_m[s] = (s == 0) ? '0 : INIT_BIG;   // encoder starts in state 0
      end else begin
        old_m[s] = ostatem[s];
        if (all_top)
          old_m[s][`VIT_METRIC_W-1] = 1'b0;    // minus 2**(W-1) for all
      end
    end
  end

  // ------------------------------
  // add compare select
  // ------------------------------

  always_comb begin
    state_t  ps0;
    state_t  ps1;
    metric_t sum0;
    metric_t sum1;
    for (int s = 0; s < `VIT_STATE_NUM; s++) begin
      ps0  = pre_state(state_t'(s), 1'b0);
      ps1  = pre_state(state_t'(s), 1'b1);
      sum0 = old_m[ps0] + branch_metric(ps0, s[0], sym);
      sum1 = old_m[ps1] + branch_metric(ps1, s[0], sym);
      new_dec[s] = (sum1 < sum0);            // tie keeps bit 0
      new_m[s]   = new_dec[s] ? sum1 : sum0;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
    end else begin
      oval <= val;
      osop <= val & sop;
      oeop <= val & eop;
    end
  end

  always_ff @(posedge iclk) begin
    if (val) begin
      ostatem   <= new_m;
      odecision <= new_dec;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vit_best_state.sv ====
`default_nettype none

module vit_best_state (
  input  logic             iclk,
  input  logic             ireset,
  input  logic             val,
  input  vit_pkg::statem_t statem,
  output logic             oval,
  output vit_pkg::state_t  ostate
);
  import vit_pkg::*;

  logic    val1;
  metric_t m_a;   // winner of states 0, 1
  state_t  s_a;
  metric_t m_b;   // winner of states 2, 3
  state_t  s_b;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val1 <= 1'b0;
      oval <= 1'b0;
    end else begin
      val1 <= val;
      oval <= val1;
    end
  end

  always_ff @(posedge iclk) begin
    if (val) begin
      // strict less so the lower state wins a tie
      m_a <= (statem[1] < statem[0]) ? statem[1]    : statem[0];
      s_a <= (statem[1] < statem[0]) ? state_t'(1)  : state_t'(0);
      m_b <= (statem[3] < statem[2]) ? statem[3]    : statem[2];
      s_b <= (statem[3] < statem[2]) ? state_t'(3)  : state_t'(2);
    end
    if (val1)
      ostate <= (m_b < m_a) ? s_b : s_a;
  end

endmodule

`default_nettype wire

// ==== hw/vit_trb_ctrl.sv ====
`default_nettype none

`include "vit_defines.svh"

module vit_trb_ctrl (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               sop,
  input  logic               val,
  input  logic               eop,
  input  vit_pkg::decision_t decision,
  input  vit_pkg::state_t    best_state,
  vit_trb_wr_if.ctrl         wr,
  vit_trb_cmd_if.ctrl        cmd
);
  import vit_pkg::*;

  localparam int L     = `VIT_TRB_LENGTH;
  localparam int DELAY = `VIT_K - 2;  // trigger is 1 cycle late already

  logic   wedge;                          // last write closed a buffer
  state_t pre_trb [`VIT_STATE_NUM];       // buffer start state per state

  // ------------------------------
  // ram write addressing
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr.write <= 1'b0;
      wr.waddr <= '0;
      wedge    <= 1'b0;
    end else begin
      wr.write <= val;
      if (val) begin
        if (sop | wedge) begin
          wr.waddr.bidx <= wr.waddr.bidx + 1'b1;   // fresh bank
          wr.waddr.addr <= '0;
          wedge         <= 1'b0;
        end else begin
          wr.waddr.addr <= wr.waddr.addr + 1'b1;
          wedge         <= (wr.waddr.addr == trb_idx_t'(L - 2));
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (val) begin
      wr.sop      <= sop;
      wr.eop      <= eop;
      wr.decision <= decision;
    end
  end

  // ------------------------------
  // pre traceback state
  // ------------------------------

  always_ff @(posedge iclk) begin
    state_t ps;
    if (val) begin
      for (int s = 0; s < `VIT_STATE_NUM; s++) begin
        ps = pre_state(state_t'(s), decision[s]);
        if (sop | wedge)
          pre_trb[s] <= ps;            // first symbol of the buffer
        else
          pre_trb[s] <= pre_trb[ps];   // follow survivor back
      end
    end
  end

  // ------------------------------
  // traceback triggers
  // ------------------------------

  logic val_d;
  logic do_start;
  logic do_stop;
  logic trb_offset;   // full buffer waiting for its traceback

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_d      <= 1'b0;
      do_start   <= 1'b0;
      do_stop    <= 1'b0;
      trb_offset <= 1'b0;
    end else begin
      val_d    <= val;
      do_start <= val & sop;
      do_stop  <= val & eop;
      if (do_start | do_stop)
        trb_offset <= 1'b0;
      else if (val_d & wedge)
        trb_offset <= 1'b1;
    end
  end

  logic trb_start;
  logic trb_fstart;
  logic trb_flush;
  assign trb_start  = val_d & wedge & trb_offset;      // previous buffer now traceable
  assign trb_fstart = !trb_start & do_stop & trb_offset;
  assign trb_flush  = do_stop;                         // current bank, full or not

  // latch at trigger, consumed when best state arrives
  state_t    used_pre   [`VIT_STATE_NUM];
  state_t    used_f_pre [`VIT_STATE_NUM];
  trb_bidx_t trb_bidx;
  trb_bidx_t trb_f_bidx;
  trb_idx_t  trb_fsize;
  trb_addr_t trb_fraddr;

  always_ff @(posedge iclk) begin
    if (val_d & wedge)
      used_pre <= pre_trb;
    if (trb_fstart) begin
      used_f_pre <= pre_trb;
      trb_f_bidx <= wr.waddr.bidx - 1'b1;
    end
    if (trb_start)
      trb_bidx <= wr.waddr.bidx - 1'b1;
    if (trb_flush) begin
      trb_fsize  <= wr.waddr.addr;   // last written word
      trb_fraddr <= wr.waddr;
    end
  end

  // ------------------------------
  // align with best state search
  // ------------------------------

  logic [DELAY-1:0] start_line;
  logic [DELAY-1:0] fstart_line;
  logic [DELAY-1:0] flush_line;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      start_line  <= '0;
      fstart_line <= '0;
      flush_line  <= '0;
    end else begin
      start_line[0]  <= trb_start;
      fstart_line[0] <= trb_fstart;
      flush_line[0]  <= trb_flush;
      for (int i = 1; i < DELAY; i++) begin
        start_line[i]  <= start_line[i-1];
        fstart_line[i] <= fstart_line[i-1];
        flush_line[i]  <= flush_line[i-1];
      end
    end
  end

  logic st_trig;
  logic fl_trig;
  assign st_trig = start_line[DELAY-1] | fstart_line[DELAY-1];
  assign fl_trig = flush_line[DELAY-1];

  // ------------------------------
  // command outputs
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cmd.start <= 1'b0;
      cmd.flush <= 1'b0;
    end else begin
      if (st_trig)
        cmd.start <= 1'b1;              // new request, or back to back
      else if (cmd.rdy)
        cmd.start <= 1'b0;              // taken by engine
      if (fl_trig)
        cmd.flush <= 1'b1;
      else if (!cmd.start & cmd.rdy)
        cmd.flush <= 1'b0;              // flush goes after any start
    end
  end

  assign cmd.size_m1 = trb_idx_t'(L - 1);   // regular traceback is always full

  always_ff @(posedge iclk) begin
    if (st_trig) begin
      cmd.raddr.bidx <= start_line[DELAY-1] ? trb_bidx : trb_f_bidx;
      cmd.raddr.addr <= trb_idx_t'(L - 1);
      cmd.state      <= start_line[DELAY-1] ? used_pre[best_state] : used_f_pre[best_state];
    end
    if (fl_trig) begin
      cmd.fsize_m1 <= trb_fsize;
      cmd.fraddr   <= trb_fraddr;
      cmd.fstate   <= best_state;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vit_trb_engine.sv ====
`default_nettype none

`include "vit_defines.svh"

module vit_trb_engine (
  input  logic          iclk,
  input  logic          ireset,
  vit_trb_wr_if.ram     wr,
  vit_trb_cmd_if.engine cmd,
  output logic          dout,
  output logic          dout_val,
  output logic          dout_sop,
  output logic          dout_eop
);
  import vit_pkg::*;

  decision_t ram [`VIT_BANK_NUM*`VIT_TRB_LENGTH];   // {bidx, addr} index

  // ------------------------------
  // decision ram write side
  // ------------------------------

  logic frame_open;
  logic ram_we;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)
      frame_open <= 1'b0;
    else if (wr.write) begin
      if (wr.sop)
        frame_open <= !wr.eop;
      else if (wr.eop)
        frame_open <= 1'b0;
    end
  end

  assign ram_we = wr.write & (wr.sop | frame_open);   // drop words outside a frame

  always_ff @(posedge iclk) begin
    if (ram_we)
      ram[wr.waddr] <= wr.decision;
  end

  // ------------------------------
  // traceback walker
  // ------------------------------

  logic      take_start;
  logic      take_flush;
  logic      rd_act;      // read cycles
  logic      rd_first;
  trb_addr_t rd_addr;
  trb_idx_t  rd_cnt;      // reads left minus one
  logic      dv;          // ram data valid
  logic      dv_first;
  logic      dv_last;
  decision_t rd_dec;
  state_t    cur_state;

  assign take_start = cmd.start & cmd.rdy;
  assign take_flush = cmd.flush & !cmd.start & cmd.rdy;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cmd.rdy  <= 1'b1;
      rd_act   <= 1'b0;
      rd_first <= 1'b0;
      dv       <= 1'b0;
      dv_first <= 1'b0;
      dv_last  <= 1'b0;
      dout_val <= 1'b0;
      dout_sop <= 1'b0;
      dout_eop <= 1'b0;
    end else begin
      if (take_start | take_flush) begin
        cmd.rdy  <= 1'b0;
        rd_act   <= 1'b1;
        rd_first <= 1'b1;
      end else if (rd_act) begin
        rd_first <= 1'b0;
        if (rd_cnt == '0)
          rd_act <= 1'b0;
      end
      if (dout_eop)
        cmd.rdy <= 1'b1;          // last bit is out
      dv       <= rd_act;
      dv_first <= rd_act & rd_first;
      dv_last  <= rd_act & (rd_cnt == '0);
      dout_val <= dv;
      dout_sop <= dv_first;
      dout_eop <= dv_last;
    end
  end

  always_ff @(posedge iclk) begin
    if (take_start | take_flush) begin
      rd_addr   <= take_start ? cmd.raddr   : cmd.fraddr;
      rd_cnt    <= take_start ? cmd.size_m1 : cmd.fsize_m1;
      cur_state <= take_start ? cmd.state   : cmd.fstate;
    end else begin
      if (rd_act) begin
        rd_addr.addr <= rd_addr.addr - 1'b1;   // backwards in the bank
        rd_cnt       <= rd_cnt - 1'b1;
      end
      if (dv) begin
        dout      <= cur_state[0];             // newest input bit of state
        cur_state <= pre_state(cur_state, rd_dec[cur_state]);
      end
    end
    rd_dec <= ram[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hw/vit_dec_top.sv ====
`default_nettype none

module vit_dec_top (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       sop,
  input  logic       val,
  input  logic       eop,
  input  logic [1:0] sym,
  output logic       dout,
  output logic       dout_val,
  output logic       dout_sop,
  output logic       dout_eop
);
  import vit_pkg::*;

  logic      acs_val;
  logic      acs_sop;
  logic      acs_eop;
  statem_t   acs_statem;
  decision_t acs_decision;
  state_t    best_state;

  vit_trb_wr_if  wr_if ();
  vit_trb_cmd_if cmd_if ();

  // metrics and decisions, 1 cycle
  vit_acs acs (
    .iclk      (iclk),
    .ireset    (ireset),
    .sop       (sop),
    .val       (val),
    .eop       (eop),
    .sym       (sym),
    .oval      (acs_val),
    .osop      (acs_sop),
    .oeop      (acs_eop),
    .ostatem   (acs_statem),
    .odecision (acs_decision)
  );

  // 2 cycles, the controller delay line matches it
  vit_best_state best (
    .iclk   (iclk),
    .ireset (ireset),
    .val    (acs_val),
    .statem (acs_statem),
    .oval   (),
    .ostate (best_state)
  );

  vit_trb_ctrl ctrl (
    .iclk       (iclk),
    .ireset     (ireset),
    .sop        (acs_sop),
    .val        (acs_val),
    .eop        (acs_eop),
    .decision   (acs_decision),
    .best_state (best_state),
    .wr         (wr_if.ctrl),
    .cmd        (cmd_if.ctrl)
  );

  vit_trb_engine engine (
    .iclk     (iclk),
    .ireset   (ireset),
    .wr       (wr_if.ram),
    .cmd      (cmd_if.engine),
    .dout     (dout),
    .dout_val (dout_val),
    .dout_sop (dout_sop),
    .dout_eop (dout_eop)
  );

endmodule

`default_nettype wire

// ==== test/tb_vit_dec.sv ====
`default_nettype none

module tb_vit_dec;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          L       = 16;          // traceback buffer length
  localparam int          GAP     = 2 * L + 8;   // minimum idle cycles between frames
  localparam int          TIMEOUT = 400;         // idle cycles before giving up
  localparam logic [2:0]  G0      = 3'o7;        // sym[0]
  localparam logic [2:0]  G1      = 3'o5;        // sym[1]
  localparam logic [31:0] SEED    = 32'h043c_b721;

  logic       iclk;
  logic       ireset;
  logic       sop;
  logic       val;
  logic       eop;
  logic [1:0] sym;
  logic       dout;
  logic       dout_val;
  logic       dout_sop;
  logic       dout_eop;

  vit_dec_top UUT (
    .iclk     (iclk),
    .ireset   (ireset),
    .sop      (sop),
    .val      (val),
    .eop      (eop),
    .sym      (sym),
    .dout     (dout),
    .dout_val (dout_val),
    .dout_sop (dout_sop),
    .dout_eop (dout_eop)
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;   // 20 ns period
  end

  // ------------------------------
  // scoreboard
  // ------------------------------

  logic       exp_q [$];     // data plus tail bits, all frames of a test
  logic       got_q [$];     // decoded bits, segments already reversed
  logic       seg_q [$];     // segment being collected, last-first
  logic [1:0] frame_q [$];   // coded symbols of one frame
  int         exp_segs;
  int         got_segs;
  int         test_errs;
  int         n_checks;
  int         n_tests;
  int         n_failed;
  string      cur_test;
  string      first_fail;    // first problem of the running test
  logic       timed_out;

  function automatic void note_error(input string msg);
    test_errs++;
    if (first_fail == "")
      first_fail = msg;
  endfunction

  // outputs change on the rising edge, so look at them on the falling one
  always @(negedge iclk) begin
    if (!ireset) begin
      if (dout_val) begin
        if ((seg_q.size() == 0) != dout_sop)
          note_error($sformatf("%s: dout_sop is not on the first bit of a segment", cur_test));
        seg_q.push_back(dout);
        if (dout_eop) begin
          if (seg_q.size() > L)
            note_error($sformatf("%s: a segment of %0d bits is longer than the buffer",
                                 cur_test, seg_q.size()));
          for (int i = seg_q.size() - 1; i >= 0; i--)
            got_q.push_back(seg_q[i]);   // back to symbol order
          seg_q.delete();
          got_segs++;
        end
      end else if (dout_sop || dout_eop) begin
        note_error($sformatf("%s: dout_sop or dout_eop came without dout_val", cur_test));
      end
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic start_test(input string name);
    cur_test   = name;
    first_fail = "";
    test_errs  = 0;
    exp_segs   = 0;
    got_segs   = 0;
    timed_out  = 1'b0;
    exp_q.delete();
    got_q.delete();
    seg_q.delete();
    frame_q.delete();
  endtask

  // random data, two zero tail bits, 7/5 encoder
  task automatic make_frame(input int nbits);
    logic [2:0] sr;   // {u, previous, one before}
    logic       u;
    frame_q.delete();
    sr = 3'b000;
    for (int i = 0; i < nbits + 2; i++) begin
      u  = (i < nbits) ? 1'($urandom()) : 1'b0;
      sr = {u, sr[2:1]};
      frame_q.push_back({^(sr & G1), ^(sr & G0)});
      exp_q.push_back(u);
    end
    exp_segs += (nbits + 2 + L - 1) / L;   // full buffers, then a partial one
  endtask

  task automatic flip_code_bit(input int idx, input int b);
    logic [1:0] s;
    s        = frame_q[idx];
    s[b]     = ~s[b];          // channel error
    frame_q[idx] = s;
  endtask

  task automatic drive_frame();
    for (int i = 0; i < frame_q.size(); i++) begin
      @(negedge iclk);
      val = 1'b1;
      sop = (i == 0);
      eop = (i == frame_q.size() - 1);
      sym = frame_q[i];
    end
    @(negedge iclk);
    val = 1'b0;
    sop = 1'b0;
    eop = 1'b0;
    sym = 2'b00;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge iclk);
  endtask

  // idle count restarts whenever a new bit shows up
  task automatic wait_for_bits();
    int idle;
    int seen;
    idle = 0;
    seen = got_q.size() + seg_q.size();
    while (got_q.size() < exp_q.size() && idle < TIMEOUT) begin
      @(posedge iclk);
      if (got_q.size() + seg_q.size() != seen) begin
        seen = got_q.size() + seg_q.size();
        idle = 0;
      end else begin
        idle++;
      end
    end
    timed_out = (got_q.size() < exp_q.size());
    idle_cycles(4);   // room for a stray extra segment
  endtask

  task automatic check_stream();
    if (timed_out) begin
      note_error($sformatf("%s: timed out waiting for decoded bits, %0d of %0d arrived",
                           cur_test, got_q.size(), exp_q.size()));
    end else begin
      n_checks += 2;
      if (got_segs != exp_segs)
        note_error($sformatf("FAIL %s: segments expected %0d actual %0d",
                             cur_test, exp_segs, got_segs));
      if (got_q.size() != exp_q.size())
        note_error($sformatf("FAIL %s: bit count expected %0d actual %0d",
                             cur_test, exp_q.size(), got_q.size()));
      for (int i = 0; i < exp_q.size(); i++) begin
        n_checks++;
        if (got_q[i] !== exp_q[i])
          note_error($sformatf("FAIL %s: bit %0d expected %0b actual %0b",
                               cur_test, i, exp_q[i], got_q[i]));
      end
    end
  endtask

  task automatic finish_test();
    n_tests++;
    if (test_errs == 0) begin
      $display("ok   %s, %0d bits in %0d segments", cur_test, got_q.size(), got_segs);
    end else begin
      n_failed++;
      $display("%s (%0d errors in this test)", first_fail, test_errs);
    end
  endtask

  // ------------------------------
  // tests
  // ------------------------------

  task automatic idle_after_reset();
    start_test("idle_after_reset");
    for (int c = 0; c < 50; c++) begin
      @(negedge iclk);
      n_checks++;
      if ({dout_val, dout_sop, dout_eop} !== 3'b000)
        note_error($sformatf("FAIL %s: cycle %0d expected 000 actual %b%b%b",
                             cur_test, c, dout_val, dout_sop, dout_eop));
    end
    finish_test();
  endtask

  task automatic clean_frame(input string name, input int nbits);
    start_test(name);
    idle_cycles(GAP);
    make_frame(nbits);
    drive_frame();
    wait_for_bits();
    check_stream();
    finish_test();
  endtask

  // isolated errors, 14 symbols apart
  task automatic single_code_errors();
    start_test("single_code_errors");
    idle_cycles(GAP);
    make_frame(60);
    flip_code_bit(5, 0);
    flip_code_bit(19, 1);
    flip_code_bit(33, 0);
    flip_code_bit(47, 1);
    drive_frame();
    wait_for_bits();
    check_stream();
    finish_test();
  endtask

  // frames at the minimum gap, output of one overlaps the next frame
  task automatic three_frames();
    start_test("three_frames");
    idle_cycles(GAP);
    make_frame(30);
    drive_frame();
    idle_cycles(GAP);
    make_frame(40);
    drive_frame();
    idle_cycles(GAP);
    make_frame(20);
    drive_frame();
    wait_for_bits();
    check_stream();
    finish_test();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    void'($urandom(SEED));
    ireset   = 1'b1;
    sop      = 1'b0;
    val      = 1'b0;
    eop      = 1'b0;
    sym      = 2'b00;
    n_checks = 0;
    n_tests  = 0;
    n_failed = 0;
    cur_test = "reset";
    first_fail = "";
    test_errs  = 0;
    repeat (3) @(negedge iclk);   // 3 rising edges in reset
    ireset = 1'b0;

    idle_after_reset();
    clean_frame("frame_50_bits", 50);           // 52 symbols, partial last buffer
    clean_frame("frame_full_last_buffer", 46);  // 48 symbols, three full buffers
    single_code_errors();
    three_frames();

    $display("tests %0d, failed %0d, checks %0d", n_tests, n_failed, n_checks);
    if (n_failed == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/vit_pkg.sv
hw/vit_trb_if.sv
hw/vit_acs.sv
hw/vit_best_state.sv
hw/vit_trb_ctrl.sv
hw/vit_trb_engine.sv
hw/vit_dec_top.sv
test/tb_vit_dec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the viterbi decoder testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_vit_dec \
    -Mdir obj_dir -o sim -f compile.f \
  && ./obj_dir/sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
